/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_s16b_main
FILELIST = verilog.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/s16b_bus_decode.sv */
// Fixed System 16B region map from addr[22:20]; addr[23] is ignored and selects follow as_n by one clk
`timescale 1ns/10ps
`default_nettype none

module s16b_bus_decode (
    input  wire         clk,
    input  wire         rst,
    input  wire  [23:1] addr,
    input  wire         as_n,
    input  wire         bus_n,
    input  wire         rnw,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        objram_cs,
    output logic        pal_cs,
    output logic        io_cs,
    output logic        tbank_cs
);

    s16b_pkg::region_e region;
    logic              is_rom;
    logic              is_vram;

    assign region  = s16b_pkg::region_e'(addr[22:20]);
    assign is_rom  = region == s16b_pkg::REG_ROM0 ||
                     region == s16b_pkg::REG_ROM1 ||
                     region == s16b_pkg::REG_ROM2;
    assign is_vram = region == s16b_pkg::REG_VRAM;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            objram_cs <= 1'b0;
            pal_cs    <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else if (!as_n) begin
            rom_cs    <= is_rom && rnw;
            tbank_cs  <= region == s16b_pkg::REG_ROM2 && !rnw; // Latch shares the ROM window
            char_cs   <= is_vram && addr[16];
            objram_cs <= region == s16b_pkg::REG_ORAM;
            pal_cs    <= region == s16b_pkg::REG_PAL;
            io_cs     <= region == s16b_pkg::REG_IO;
            // RAM selects drop between the halves of a read-modify-write
            vram_cs   <= !bus_n && is_vram && !addr[16];
            ram_cs    <= !bus_n && region == s16b_pkg::REG_RAM;
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            objram_cs <= 1'b0;
            pal_cs    <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/s16b_cabinet_io.sv */
// Cabinet inputs and video registers; only the low data byte is written and read back
`timescale 1ns/10ps
`default_nettype none

`include "s16b_consts.svh"

module s16b_cabinet_io (
    input  wire         clk,
    input  wire         rst,
    input  wire         io_cs,
    input  wire         tbank_cs,
    input  wire  [13:1] addr,
    input  wire         lds_wn,
    input  wire  [7:0]  cpu_dout,
    input  wire  [7:0]  joystick1,
    input  wire  [7:0]  joystick2,
    input  wire  [1:0]  start_button,
    input  wire  [1:0]  coin_input,
    input  wire         service,
    input  wire         dip_test,
    input  wire  [7:0]  dipsw_a,
    input  wire  [7:0]  dipsw_b,
    output logic [7:0]  cab_dout,
    output logic        flip,
    output logic        video_en,
    output logic [5:0]  tile_bank
);

    localparam logic [15:0] IDLE = `BUS_IDLE;

    s16b_pkg::io_group_e group;

    // Board wiring order of the joystick lines
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1], joy[0], joy[3], joy[2], joy[7], joy[5], joy[4], joy[6]};
    endfunction

    assign group = s16b_pkg::io_group_e'(addr[13:12]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout  <= IDLE[7:0];
            flip      <= 1'b0;
            video_en  <= 1'b1; // Screen on out of reset
            tile_bank <= '0;
        end else begin
            if (tbank_cs && !lds_wn) begin
                if (addr[1])
                    tile_bank[5:3] <= cpu_dout[2:0];
                else
                    tile_bank[2:0] <= cpu_dout[2:0];
            end
            if (io_cs && group == s16b_pkg::IO_VIDEO && !lds_wn) begin
                flip     <= cpu_dout[6];
                video_en <= cpu_dout[5];
            end
            // Read value follows the address and is ready together with io_cs
            case (group)
                s16b_pkg::IO_PLAYER: begin
                    case (addr[2:1])
                        2'd0: cab_dout <= {2'b11, start_button, service, dip_test, coin_input};
                        2'd1: cab_dout <= sort_joy(joystick1);
                        2'd3: cab_dout <= sort_joy(joystick2);
                        default: cab_dout <= IDLE[7:0];
                    endcase
                end
                s16b_pkg::IO_DIP: cab_dout <= addr[1] ? dipsw_b : dipsw_a;
                default: cab_dout <= IDLE[7:0]; // Video group and group 3 read as ones
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/s16b_cen_frac.sv */
// Fractional enable at CEN_NUM/CEN_DEN of clk; pulse spacing jitters by one clk around the mean
`timescale 1ns/10ps
`default_nettype none

`include "s16b_consts.svh"

module s16b_cen_frac (
    input  wire  clk,
    input  wire  rst,
    output logic cpu_cen,
    output logic cpu_cenb
);

    localparam logic [`CEN_W:0] NUM  = `CEN_NUM;
    localparam logic [`CEN_W:0] DEN  = `CEN_DEN;
    localparam logic [`CEN_W:0] HALF = `CEN_DEN / 2;

    logic [`CEN_W-1:0] acc;
    logic [`CEN_W:0]   sum;  // One extra bit for the overflow check
    logic [`CEN_W:0]   wrap;

    assign sum  = {1'b0, acc} + NUM;
    assign wrap = sum - DEN;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
            if (sum >= DEN) begin
                acc     <= wrap[`CEN_W-1:0];
                cpu_cen <= 1'b1;
            end else begin
                acc <= sum[`CEN_W-1:0];
                // Crossing the midpoint marks the second half of the CPU cycle
                cpu_cenb <= ({1'b0, acc} < HALF) && (sum >= HALF);
            end
        end
    end

endmodule

`default_nettype wire

/* logic/s16b_consts.svh */
// Bus glue constants; CEN_W must hold CEN_DEN + CEN_NUM - 1 and CEN_NUM must stay below CEN_DEN/2
`ifndef S16B_CONSTS_SVH
`define S16B_CONSTS_SVH

// CPU clock enable ratio, clk * 29/146
`define CEN_NUM 29
`define CEN_DEN 146

// Accumulator width for the enable generator
`define CEN_W 8

// Read value of an undriven data bus
`define BUS_IDLE 16'hffff

`endif

/* logic/s16b_dtack.sv */
// DTACK on a CPU clock enable once the access is ready; held until as_n rises with no bus error path
`timescale 1ns/10ps
`default_nettype none

module s16b_dtack (
    input  wire  clk,
    input  wire  rst,
    input  wire  cpu_cen,
    input  wire  as_n,
    input  wire  bus_n,
    input  wire  bus_cs,
    input  wire  bus_busy,
    output logic dtack_n
);

    s16b_pkg::dtack_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= s16b_pkg::DT_IDLE;
        end else begin
            case (state)
                s16b_pkg::DT_IDLE: begin
                    if (bus_cs && !bus_n)
                        state <= s16b_pkg::DT_WAIT_READY;
                end
                s16b_pkg::DT_WAIT_READY: begin
                    // Stretch here while the memory is not ready
                    if (as_n)
                        state <= s16b_pkg::DT_IDLE;
                    else if (!bus_busy && cpu_cen)
                        state <= s16b_pkg::DT_ACKED;
                end
                s16b_pkg::DT_ACKED: begin
                    if (as_n)
                        state <= s16b_pkg::DT_IDLE;
                end
                default: state <= s16b_pkg::DT_IDLE;
            endcase
        end
    end

    assign dtack_n = state != s16b_pkg::DT_ACKED;

endmodule

`default_nettype wire

/* logic/s16b_main.sv */
// Main bus glue without CPU; ROM data passes undecrypted and unmapped reads keep the last bus value
`timescale 1ns/10ps
`default_nettype none

`include "s16b_consts.svh"

module s16b_main (
    input  wire         clk,
    input  wire         rst,
    input  wire  [23:1] addr,
    input  wire         as_n,
    input  wire         uds_n,
    input  wire         lds_n,
    input  wire         rnw,
    input  wire  [15:0] cpu_dout,
    input  wire  [15:0] rom_data,
    input  wire         rom_ok,
    input  wire  [15:0] ram_data,
    input  wire         ram_ok,
    input  wire  [15:0] char_dout,
    input  wire  [15:0] pal_dout,
    input  wire  [15:0] obj_dout,
    input  wire  [7:0]  joystick1,
    input  wire  [7:0]  joystick2,
    input  wire  [1:0]  start_button,
    input  wire  [1:0]  coin_input,
    input  wire         service,
    input  wire         dip_test,
    input  wire  [7:0]  dipsw_a,
    input  wire  [7:0]  dipsw_b,
    output logic        cpu_cen,
    output logic        cpu_cenb,
    output logic [15:0] cpu_din,
    output logic        dtack_n,
    output logic        uds_wn,
    output logic        lds_wn,
    output logic        rom_cs,
    output logic [18:1] rom_addr,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        objram_cs,
    output logic        pal_cs,
    output logic        flip,
    output logic        video_en,
    output logic [5:0]  tile_bank
);

    localparam logic [15:0] IDLE = `BUS_IDLE;

    logic       bus_n;
    logic       io_cs;
    logic       tbank_cs;
    logic       bus_cs;
    logic       bus_busy;
    logic [7:0] cab_dout;

    assign uds_wn   = rnw | uds_n;
    assign lds_wn   = rnw | lds_n;
    assign bus_n    = as_n | (uds_n & lds_n);
    assign rom_addr = addr[18:1];  // 512 kB program space

    assign bus_cs   = rom_cs | ram_cs | vram_cs | char_cs | objram_cs | pal_cs | io_cs | tbank_cs;
    assign bus_busy = (rom_cs & ~rom_ok) | ((ram_cs | vram_cs) & ~ram_ok);

    s16b_cen_frac u_cen (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb)
    );

    s16b_bus_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .as_n      (as_n),
        .bus_n     (bus_n),
        .rnw       (rnw),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .objram_cs (objram_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs)
    );

    s16b_cabinet_io u_cab (
        .clk          (clk),
        .rst          (rst),
        .io_cs        (io_cs),
        .tbank_cs     (tbank_cs),
        .addr         (addr[13:1]),
        .lds_wn       (lds_wn),
        .cpu_dout     (cpu_dout[7:0]),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .flip         (flip),
        .video_en     (video_en),
        .tile_bank    (tile_bank)
    );

    s16b_dtack u_dtack (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .as_n     (as_n),
        .bus_n    (bus_n),
        .bus_cs   (bus_cs),
        .bus_busy (bus_busy),
        .dtack_n  (dtack_n)
    );

    // Read data into the CPU
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= IDLE;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;  // Work RAM and VRAM share one port
        end else if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (io_cs) begin
            cpu_din <= {IDLE[15:8], cab_dout};
        end
    end

endmodule

`default_nettype wire

/* logic/s16b_pkg.sv */
// Shared types of the bus glue; the region map is fixed and has no programmable mapper
`default_nettype none

package s16b_pkg;

    // Region from addr[22:20]
    typedef enum logic [2:0] {
        REG_ROM0 = 3'd0,
        REG_ROM1 = 3'd1,
        REG_ROM2 = 3'd2, // Also the tile-bank latch on writes
        REG_RAM  = 3'd3,
        REG_ORAM = 3'd4,
        REG_VRAM = 3'd5,
        REG_PAL  = 3'd6,
        REG_IO   = 3'd7
    } region_e;

    // I/O group from addr[13:12]
    typedef enum logic [1:0] {
        IO_VIDEO  = 2'd0,
        IO_PLAYER = 2'd1,
        IO_DIP    = 2'd2,
        IO_UNUSED = 2'd3
    } io_group_e;

    typedef enum logic [1:0] {
        DT_IDLE,
        DT_WAIT_READY,
        DT_ACKED
    } dtack_state_e;

endpackage

`default_nettype wire

/* sim/s16b_clk_gen.sv */
// Free-running testbench clock starting low at time zero; PERIOD is in ns and must be even
`timescale 1ns/10ps
`default_nettype none

module s16b_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* sim/s16b_stimulus.txt */
// op addr wdata mem_data ok_delay cs_mask exp_din exp_regs, all hex; op 0 read, 1 write, 3 write lds_n high
// cs_mask bits 0..5 rom ram vram char obj pal; exp_regs is {flip, video_en, tile_bank[5:0]}
0 000100 0000 1234 0 01 1234 40
0 1a0000 0000 abcd 5 01 abcd 40
0 2f0000 0000 0f0f 0 01 0f0f 40
0 3f8000 0000 5555 0 02 5555 40
0 3f8002 0000 6789 9 02 6789 40
1 3f8004 1357 0000 3 02 0000 40
0 440000 0000 2468 0 10 2468 40
0 500000 0000 9abc 0 04 9abc 40
0 500000 0000 1111 4 04 1111 40
0 510000 0000 cafe 0 08 cafe 40
0 600400 0000 beef 0 20 beef 40
0 701000 0000 0000 0 00 ffe5 40
0 701002 0000 0000 0 00 ffa3 40
0 701004 0000 0000 0 00 ffff 40
0 701006 0000 0000 0 00 ff48 40
0 702000 0000 0000 0 00 ff3c 40
0 702002 0000 0000 0 00 ffc7 40
0 703000 0000 0000 0 00 ffff 40
1 700000 0040 0000 0 00 0000 80
3 700000 0020 0000 0 00 0000 80
1 200000 0005 0000 0 00 0000 85
1 200002 0003 0000 0 00 0000 9d
3 200000 0007 0000 0 00 0000 9d
1 700000 0060 0000 0 00 0000 dd
0 000002 0000 8001 2 01 8001 dd
1 700000 0000 0000 0 00 0000 1d

/* sim/tb_s16b_main.sv */
// Testbench acting as the 68000; run from the project root so the stimulus file path resolves
`timescale 1ns/10ps
`default_nettype none

`include "s16b_consts.svh"

module tb_s16b_main;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 16;
    localparam int CEN_WINDOW   = 1460;
    localparam int LINES        = 26;
    localparam int FIELDS       = 8;  // Words per stimulus line

    logic        clk;
    logic        rst;
    logic [23:1] addr;
    logic        as_n;
    logic        uds_n;
    logic        lds_n;
    logic        rnw;
    logic [15:0] cpu_dout;
    logic [15:0] rom_data;
    logic        rom_ok;
    logic [15:0] ram_data;
    logic        ram_ok;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic        cpu_cen;
    logic        cpu_cenb;
    logic [15:0] cpu_din;
    logic        dtack_n;
    logic        uds_wn;
    logic        lds_wn;
    logic        rom_cs;
    logic [18:1] rom_addr;
    logic        ram_cs;
    logic        vram_cs;
    logic        char_cs;
    logic        objram_cs;
    logic        pal_cs;
    logic        flip;
    logic        video_en;
    logic [5:0]  tile_bank;

    logic [31:0] stim [0:LINES*FIELDS-1];
    bit          loaded = 1'b0;

    s16b_clk_gen #(.PERIOD(PERIOD)) u_clk_gen (.clk(clk));

    s16b_main u_s16b_main (
        .clk(clk), .rst(rst), .addr(addr), .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n),
        .rnw(rnw), .cpu_dout(cpu_dout), .rom_data(rom_data), .rom_ok(rom_ok),
        .ram_data(ram_data), .ram_ok(ram_ok), .char_dout(char_dout), .pal_dout(pal_dout),
        .obj_dout(obj_dout), .joystick1(joystick1), .joystick2(joystick2),
        .start_button(start_button), .coin_input(coin_input), .service(service),
        .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .cpu_cen(cpu_cen),
        .cpu_cenb(cpu_cenb), .cpu_din(cpu_din), .dtack_n(dtack_n), .uds_wn(uds_wn),
        .lds_wn(lds_wn), .rom_cs(rom_cs), .rom_addr(rom_addr), .ram_cs(ram_cs),
        .vram_cs(vram_cs), .char_cs(char_cs), .objram_cs(objram_cs), .pal_cs(pal_cs),
        .flip(flip), .video_en(video_en), .tile_bank(tile_bank)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, got);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // One 68000 bus cycle from one stimulus line
    task automatic run_cycle(input int line);
        logic [31:0] op;
        logic [31:0] byte_addr;
        logic [31:0] mem;
        logic [31:0] mask;
        logic [31:0] regs;
        logic [15:0] prev_din;
        int          delay;
        int          i;
        op        = stim[line*FIELDS];
        byte_addr = stim[line*FIELDS+1];
        mem       = stim[line*FIELDS+3];
        delay     = int'(stim[line*FIELDS+4]);
        mask      = stim[line*FIELDS+5];
        regs      = stim[line*FIELDS+7];
        @(posedge clk);
        addr      <= byte_addr[23:1];
        rnw       <= !op[0];
        cpu_dout  <= stim[line*FIELDS+2][15:0];
        as_n      <= 1'b0;
        uds_n     <= 1'b0;
        lds_n     <= op[1];
        // Memories that should stay unselected present inverted data
        rom_data  <= mask[0] ? mem[15:0] : ~mem[15:0];
        ram_data  <= (mask[1] | mask[2]) ? mem[15:0] : ~mem[15:0];
        char_dout <= mask[3] ? mem[15:0] : ~mem[15:0];
        obj_dout  <= mask[4] ? mem[15:0] : ~mem[15:0];
        pal_dout  <= mask[5] ? mem[15:0] : ~mem[15:0];
        if (delay != 0) begin
            rom_ok <= 1'b0;
            ram_ok <= 1'b0;
        end
        for (i = 0; i < delay; i++) begin
            @(negedge clk);
            check_value("dtack_n while not ready", 32'(dtack_n), 32'h1);
        end
        @(posedge clk);
        rom_ok <= 1'b1;
        ram_ok <= 1'b1;
        @(negedge clk);
        while (dtack_n) begin
            prev_din = cpu_din;  // Read data must settle a clk ahead of DTACK
            @(negedge clk);
        end
        check_value("chip selects", 32'({pal_cs, objram_cs, char_cs, vram_cs, ram_cs, rom_cs}),
                    mask);
        check_value("rom_addr", 32'(rom_addr), 32'(byte_addr[18:1]));
        check_value("uds_wn", 32'(uds_wn), 32'(!op[0]));
        check_value("lds_wn", 32'(lds_wn), 32'(!(op[0] && !op[1])));
        if (!op[0]) begin
            check_value("cpu_din one clk before dtack_n", 32'(prev_din),
                        32'(stim[line*FIELDS+6][15:0]));
            check_value("cpu_din", 32'(cpu_din), 32'(stim[line*FIELDS+6][15:0]));
        end
        check_value("flip", 32'(flip), 32'(regs[7]));
        check_value("video_en", 32'(video_en), 32'(regs[6]));
        check_value("tile_bank", 32'(tile_bank), 32'(regs[5:0]));
        @(posedge clk);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        rnw   <= 1'b1;
        @(negedge clk);
        while (!dtack_n)
            @(negedge clk);
        check_value("chip selects after cycle",
                    32'({pal_cs, objram_cs, char_cs, vram_cs, ram_cs, rom_cs}), 32'h0);
        repeat (2) @(posedge clk);  // Bus idle between cycles
    endtask

    initial begin : main_seq
        int line;
        int k;
        int cen_count;
        int cenb_count;
        int cen_expect;
        rst          = 1'b1;
        addr         = '0;
        as_n         = 1'b1;
        uds_n        = 1'b1;
        lds_n        = 1'b1;
        rnw          = 1'b1;
        cpu_dout     = '0;
        rom_data     = '0;
        rom_ok       = 1'b1;
        ram_data     = '0;
        ram_ok       = 1'b1;
        char_dout    = '0;
        pal_dout     = '0;
        obj_dout     = '0;
        joystick1    = 8'h5a;
        joystick2    = 8'h81;
        start_button = 2'b10;
        coin_input   = 2'b01;
        service      = 1'b0;
        dip_test     = 1'b1;
        dipsw_a      = 8'h3c;
        dipsw_b      = 8'hc7;
        $readmemh("sim/s16b_stimulus.txt", stim);
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("chip selects at reset",
                    32'({pal_cs, objram_cs, char_cs, vram_cs, ram_cs, rom_cs}), 32'h0);
        check_value("dtack_n at reset", 32'(dtack_n), 32'h1);
        check_value("cpu_din at reset", 32'(cpu_din), 32'(`BUS_IDLE));
        check_value("flip at reset", 32'(flip), 32'h0);
        check_value("video_en at reset", 32'(video_en), 32'h1);
        check_value("tile_bank at reset", 32'(tile_bank), 32'h0);
        cen_count  = 0;
        cenb_count = 0;
        for (k = 0; k < CEN_WINDOW; k++) begin
            @(negedge clk);
            if (cpu_cen)
                cen_count++;
            if (cpu_cenb)
                cenb_count++;
            check_value("cpu_cen with cpu_cenb", 32'(cpu_cen & cpu_cenb), 32'h0);
        end
        cen_expect = CEN_WINDOW * `CEN_NUM / `CEN_DEN;
        if (cen_count < cen_expect - 1 || cen_count > cen_expect + 1)
            check_value("cpu_cen pulse count", 32'(cen_count), 32'(cen_expect));
        // One cpu_cenb per CPU cycle as well
        if (cenb_count < cen_expect - 1 || cenb_count > cen_expect + 1)
            check_value("cpu_cenb pulse count", 32'(cenb_count), 32'(cen_expect));
        for (line = 0; line < LINES; line++)
            run_cycle(line);
        $display("Simulation passed");
        $finish;
    end

    // Limit grows with the number of bus cycles and the longest memory delay
    initial begin : watchdog
        int max_delay;
        int k;
        int limit;
        wait (loaded);
        max_delay = 0;
        for (k = 0; k < LINES; k++)
            if (int'(stim[k*FIELDS+4]) > max_delay)
                max_delay = int'(stim[k*FIELDS+4]);
        limit = (LINES * (max_delay + 40) + RESET_CYCLES + CEN_WINDOW) * PERIOD;
        #(limit);
        $display("Timeout: dtack_n stalled and the bus cycles did not finish in %0d ns", limit);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/s16b_pkg.sv
logic/s16b_cen_frac.sv
logic/s16b_bus_decode.sv
logic/s16b_cabinet_io.sv
logic/s16b_dtack.sv
logic/s16b_main.sv
sim/s16b_clk_gen.sv
sim/tb_s16b_main.sv
